//--- hdl/rv_exe_pkg.sv
// ----------------------------------------
// rv_exe_pkg
// shared constants for the rv32i execution pipeline
// opcodes, alu codes, branch conditions, bus address map
// and the two-view instruction word
// ----------------------------------------
`default_nettype none

package rv_exe_pkg;

	// widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_op_w   = 4;
	localparam int cnd_w      = 3;
	localparam int wb_adr_w   = 6;

	// ----------------------------------------
	// major opcodes handled
	// ----------------------------------------
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;

	// alu operation codes
	localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
	localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
	localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
	localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
	localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
	localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
	localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
	localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

	// branch conditions, same as funct3 of BRANCH
	localparam logic [cnd_w-1:0] cnd_eq  = 3'b000;
	localparam logic [cnd_w-1:0] cnd_ne  = 3'b001;
	localparam logic [cnd_w-1:0] cnd_lt  = 3'b100;
	localparam logic [cnd_w-1:0] cnd_ge  = 3'b101;
	localparam logic [cnd_w-1:0] cnd_ltu = 3'b110;
	localparam logic [cnd_w-1:0] cnd_geu = 3'b111;

	// ----------------------------------------
	// bus word addresses, 1..31 read registers
	// ----------------------------------------
	localparam logic [wb_adr_w-1:0] adr_instr = 6'd0;
	localparam logic [wb_adr_w-1:0] adr_brcnt = 6'd32;

	// instruction word, register or immediate layout
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
	} rv_instr_u;

endpackage

`default_nettype wire

//--- hdl/rv_alu.sv
// ----------------------------------------
// rv_alu
// combinational alu for the eleven ops
// plus the six branch compares
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  logic [rv_exe_pkg::xlen-1:0]     a,
	input  logic [rv_exe_pkg::xlen-1:0]     b,
	input  logic [rv_exe_pkg::alu_op_w-1:0] alu_op,
	input  logic [rv_exe_pkg::cnd_w-1:0]    cnd,
	output logic [rv_exe_pkg::xlen-1:0]     result,
	output logic                            cnd_true
);

	logic       lt_s;
	logic       lt_u;
	logic [4:0] shamt;

	// signed and unsigned less-than, shared by slt and branches
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;
	assign shamt = b[4:0];

	always_comb begin
		case (alu_op)
			rv_exe_pkg::alu_add:    result = a + b;
			rv_exe_pkg::alu_sub:    result = a - b;
			rv_exe_pkg::alu_sll:    result = a << shamt;
			rv_exe_pkg::alu_slt:    result = {31'b0, lt_s};
			rv_exe_pkg::alu_sltu:   result = {31'b0, lt_u};
			rv_exe_pkg::alu_xor:    result = a ^ b;
			rv_exe_pkg::alu_srl:    result = a >> shamt;
			// arithmetic shift keeps the sign
			rv_exe_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
			rv_exe_pkg::alu_or:     result = a | b;
			rv_exe_pkg::alu_and:    result = a & b;
			rv_exe_pkg::alu_pass_b: result = b;
			default:                result = '0;
		endcase
	end

	// branch condition
	always_comb begin
		case (cnd)
			rv_exe_pkg::cnd_eq:  cnd_true = (a == b);
			rv_exe_pkg::cnd_ne:  cnd_true = (a != b);
			rv_exe_pkg::cnd_lt:  cnd_true = lt_s;
			rv_exe_pkg::cnd_ge:  cnd_true = !lt_s;
			rv_exe_pkg::cnd_ltu: cnd_true = lt_u;
			rv_exe_pkg::cnd_geu: cnd_true = !lt_u;
			default:             cnd_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
// ----------------------------------------
// rv_regfile
// x1..x31 with x0 tied to zero
// two decode read ports, one bus read port
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [rv_exe_pkg::reg_addr_w-1:0] ra1,
	input  logic [rv_exe_pkg::reg_addr_w-1:0] ra2,
	input  logic [rv_exe_pkg::reg_addr_w-1:0] ra3,
	input  logic                              we,
	input  logic [rv_exe_pkg::reg_addr_w-1:0] wa,
	input  logic [rv_exe_pkg::xlen-1:0]       wd,
	output logic [rv_exe_pkg::xlen-1:0]       rd1,
	output logic [rv_exe_pkg::xlen-1:0]       rd2,
	output logic [rv_exe_pkg::xlen-1:0]       rd3
);

	logic [rv_exe_pkg::xlen-1:0] regs [1:31];

	// all registers clear on reset, x0 writes dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// reads see the old value during a write
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
	assign rd3 = (ra3 == '0) ? '0 : regs[ra3];

endmodule

`default_nettype wire

//--- hdl/rv_decode_stage.sv
// ----------------------------------------
// rv_decode_stage
// decode register for one issued word, field split,
// alu op select and immediate build
// register file read indices leave from here
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    instr_val,
	input  logic [31:0]                             instr,
	input  logic [rv_exe_pkg::xlen-1:0]             rs1_data,
	input  logic [rv_exe_pkg::xlen-1:0]             rs2_data,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       rs1_idx,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       rs2_idx,
	output logic                                    val,
	output logic                                    we,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       rd,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       rs1,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       rs2,
	output logic [rv_exe_pkg::xlen-1:0]             src1,
	output logic [rv_exe_pkg::xlen-1:0]             src2,
	output logic [rv_exe_pkg::xlen-1:0]             imm,
	output logic                                    use_imm,
	output logic [rv_exe_pkg::alu_op_w-1:0]         alu_op,
	output logic                                    is_branch,
	output logic [rv_exe_pkg::cnd_w-1:0]            cnd
);

	rv_exe_pkg::rv_instr_u ir;
	logic                  ir_val;
	logic                  wr_en;

	// valid bit, cleared on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ir_val <= 1'b0;
		end else begin
			ir_val <= instr_val;
		end
	end

	// word itself only loads on issue
	always_ff @(posedge clk) begin
		if (instr_val) begin
			ir <= instr;
		end
	end

	// ----------------------------------------
	// field split
	// ----------------------------------------
	assign rs1_idx = ir.r_fmt.rs1;
	assign rs2_idx = ir.r_fmt.rs2;
	assign rs1     = ir.r_fmt.rs1;
	assign rs2     = ir.r_fmt.rs2;
	assign rd      = ir.r_fmt.rd;
	assign cnd     = ir.i_fmt.funct3;
	assign val     = ir_val;
	// register file values come straight from the registered indices
	assign src1    = rs1_data;
	assign src2    = rs2_data;
	// rd of zero never writes
	assign we      = wr_en && (ir.r_fmt.rd != '0);

	// ----------------------------------------
	// op select and immediates
	// ----------------------------------------
	always_comb begin
		alu_op    = rv_exe_pkg::alu_add;
		use_imm   = 1'b0;
		is_branch = 1'b0;
		wr_en     = 1'b0;
		// i-type immediate, sign extended
		imm       = {{20{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
		case (ir.r_fmt.opcode)
			rv_exe_pkg::opc_op: begin
				wr_en = 1'b1;
				case (ir.r_fmt.funct3)
					3'd0: alu_op = ir.r_fmt.funct7[5] ? rv_exe_pkg::alu_sub : rv_exe_pkg::alu_add;
					3'd1: alu_op = rv_exe_pkg::alu_sll;
					3'd2: alu_op = rv_exe_pkg::alu_slt;
					3'd3: alu_op = rv_exe_pkg::alu_sltu;
					3'd4: alu_op = rv_exe_pkg::alu_xor;
					3'd5: alu_op = ir.r_fmt.funct7[5] ? rv_exe_pkg::alu_sra : rv_exe_pkg::alu_srl;
					3'd6: alu_op = rv_exe_pkg::alu_or;
					default: alu_op = rv_exe_pkg::alu_and;
				endcase
			end
			rv_exe_pkg::opc_op_imm: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				// no subi, shift type sits in imm bit 10
				case (ir.i_fmt.funct3)
					3'd0: alu_op = rv_exe_pkg::alu_add;
					3'd1: alu_op = rv_exe_pkg::alu_sll;
					3'd2: alu_op = rv_exe_pkg::alu_slt;
					3'd3: alu_op = rv_exe_pkg::alu_sltu;
					3'd4: alu_op = rv_exe_pkg::alu_xor;
					3'd5: alu_op = ir.i_fmt.imm12[10] ? rv_exe_pkg::alu_sra : rv_exe_pkg::alu_srl;
					3'd6: alu_op = rv_exe_pkg::alu_or;
					default: alu_op = rv_exe_pkg::alu_and;
				endcase
			end
			rv_exe_pkg::opc_lui: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				alu_op  = rv_exe_pkg::alu_pass_b;
				// upper 20 bits of the word, low 12 zero
				imm     = {ir.i_fmt.imm12, ir.i_fmt.rs1, ir.i_fmt.funct3, 12'b0};
			end
			rv_exe_pkg::opc_branch: begin
				// slt-style compare of rs1 against rs2, condition from funct3
				is_branch = 1'b1;
				alu_op    = rv_exe_pkg::alu_sub;
			end
			default: begin
				// anything else runs as a no-op
				wr_en = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_exe_stage.sv
// ----------------------------------------
// rv_exe_stage
// execution station, operand forwarding, alu
// and the execute/write-back register
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_exe_stage (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    val,
	input  logic                                    we,
	input  logic [rv_exe_pkg::reg_addr_w-1:0]       rd,
	input  logic [rv_exe_pkg::reg_addr_w-1:0]       rs1,
	input  logic [rv_exe_pkg::reg_addr_w-1:0]       rs2,
	input  logic [rv_exe_pkg::xlen-1:0]             src1,
	input  logic [rv_exe_pkg::xlen-1:0]             src2,
	input  logic [rv_exe_pkg::xlen-1:0]             imm,
	input  logic                                    use_imm,
	input  logic [rv_exe_pkg::alu_op_w-1:0]         alu_op,
	input  logic                                    is_branch,
	input  logic [rv_exe_pkg::cnd_w-1:0]            cnd,
	output logic                                    wb_val,
	output logic                                    wb_we,
	output logic [rv_exe_pkg::reg_addr_w-1:0]       wb_rd,
	output logic [rv_exe_pkg::xlen-1:0]             wb_data,
	output logic                                    br_taken
);

	logic [rv_exe_pkg::xlen-1:0] op_a;
	logic [rv_exe_pkg::xlen-1:0] fwd_b;
	logic [rv_exe_pkg::xlen-1:0] op_b;
	logic [rv_exe_pkg::xlen-1:0] alu_res;
	logic                        alu_cnd;

	// ----------------------------------------
	// forwarding
	// ----------------------------------------
	// the write-back register is also the register file write port,
	// so one match covers both the execute result and the same-cycle
	// write that the register file read does not bypass
	function automatic logic [rv_exe_pkg::xlen-1:0] fwd(
		input logic [rv_exe_pkg::reg_addr_w-1:0] idx,
		input logic [rv_exe_pkg::xlen-1:0]       rf_val
	);
		if (wb_val && wb_we && (wb_rd != '0) && (wb_rd == idx)) begin
			return wb_data;
		end
		// fall back to what decode read
		return rf_val;
	endfunction

	always_comb begin
		op_a  = fwd(rs1, src1);
		fwd_b = fwd(rs2, src2);
	end

	// immediate or rs2 as operand b
	assign op_b  = use_imm ? imm : fwd_b;

	rv_alu u_alu (
		.a        (op_a),
		.b        (op_b),
		.alu_op   (alu_op),
		.cnd      (cnd),
		.result   (alu_res),
		.cnd_true (alu_cnd)
	);

	// ----------------------------------------
	// execute/write-back register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_val   <= 1'b0;
			wb_we    <= 1'b0;
			br_taken <= 1'b0;
		end else begin
			wb_val   <= val;
			wb_we    <= val && we;
			// one-cycle pulse per taken branch
			br_taken <= val && is_branch && alu_cnd;
		end
	end

	// result and destination travel with the valid bits
	always_ff @(posedge clk) begin
		wb_rd   <= rd;
		wb_data <= alu_res;
	end

endmodule

`default_nettype wire

//--- hdl/rv_exe_top.sv
// ----------------------------------------
// rv_exe_top
// wishbone classic slave in front of the
// decode, execute and write-back pipeline
// holds the taken-branch counter
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_exe_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              cyc,
	input  logic                              stb,
	input  logic                              we,
	input  logic [rv_exe_pkg::wb_adr_w-1:0]   adr,
	input  logic [rv_exe_pkg::xlen-1:0]       dat_w,
	output logic [rv_exe_pkg::xlen-1:0]       dat_r,
	output logic                              ack
);

	logic                                bus_req;
	logic                                issue;
	logic [rv_exe_pkg::xlen-1:0]         brcnt;
	logic [rv_exe_pkg::xlen-1:0]         rf_rd1;
	logic [rv_exe_pkg::xlen-1:0]         rf_rd2;
	logic [rv_exe_pkg::xlen-1:0]         rf_rd3;
	logic [rv_exe_pkg::reg_addr_w-1:0]   dec_rs1_idx;
	logic [rv_exe_pkg::reg_addr_w-1:0]   dec_rs2_idx;
	logic                                dec_val;
	logic                                dec_we;
	logic [rv_exe_pkg::reg_addr_w-1:0]   dec_rd;
	logic [rv_exe_pkg::reg_addr_w-1:0]   dec_rs1;
	logic [rv_exe_pkg::reg_addr_w-1:0]   dec_rs2;
	logic [rv_exe_pkg::xlen-1:0]         dec_src1;
	logic [rv_exe_pkg::xlen-1:0]         dec_src2;
	logic [rv_exe_pkg::xlen-1:0]         dec_imm;
	logic                                dec_use_imm;
	logic [rv_exe_pkg::alu_op_w-1:0]     dec_alu_op;
	logic                                dec_is_branch;
	logic [rv_exe_pkg::cnd_w-1:0]        dec_cnd;
	logic                                wb_val;
	logic                                wb_we;
	logic [rv_exe_pkg::reg_addr_w-1:0]   wb_rd;
	logic [rv_exe_pkg::xlen-1:0]         wb_data;
	logic                                br_taken;

	// ----------------------------------------
	// bus side
	// ----------------------------------------
	// new request, not already being acked
	assign bus_req = cyc && stb && !ack;
	// instruction enters decode on the ack edge
	assign issue   = bus_req && we && (adr == rv_exe_pkg::adr_instr);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= bus_req;
		end
	end

	// taken branches, counted on the write-back edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			brcnt <= '0;
		end else if (br_taken) begin
			brcnt <= brcnt + 1'b1;
		end
	end

	// readback mux, adr 0 lands on x0 and reads zero
	always_comb begin
		if (adr == rv_exe_pkg::adr_brcnt) begin
			dat_r = brcnt;
		end else if (adr < rv_exe_pkg::adr_brcnt) begin
			dat_r = rf_rd3;
		end else begin
			dat_r = '0;
		end
	end

	// ----------------------------------------
	// pipeline
	// ----------------------------------------
	rv_decode_stage u_dec (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr_val (issue),
		.instr     (dat_w),
		.rs1_data  (rf_rd1),
		.rs2_data  (rf_rd2),
		.rs1_idx   (dec_rs1_idx),
		.rs2_idx   (dec_rs2_idx),
		.val       (dec_val),
		.we        (dec_we),
		.rd        (dec_rd),
		.rs1       (dec_rs1),
		.rs2       (dec_rs2),
		.src1      (dec_src1),
		.src2      (dec_src2),
		.imm       (dec_imm),
		.use_imm   (dec_use_imm),
		.alu_op    (dec_alu_op),
		.is_branch (dec_is_branch),
		.cnd       (dec_cnd)
	);

	rv_exe_stage u_exe (
		.clk       (clk),
		.rst_n     (rst_n),
		.val       (dec_val),
		.we        (dec_we),
		.rd        (dec_rd),
		.rs1       (dec_rs1),
		.rs2       (dec_rs2),
		.src1      (dec_src1),
		.src2      (dec_src2),
		.imm       (dec_imm),
		.use_imm   (dec_use_imm),
		.alu_op    (dec_alu_op),
		.is_branch (dec_is_branch),
		.cnd       (dec_cnd),
		.wb_val    (wb_val),
		.wb_we     (wb_we),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.br_taken  (br_taken)
	);

	// third read port serves the bus
	rv_regfile u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (dec_rs1_idx),
		.ra2   (dec_rs2_idx),
		.ra3   (adr[rv_exe_pkg::reg_addr_w-1:0]),
		.we    (wb_val && wb_we),
		.wa    (wb_rd),
		.wd    (wb_data),
		.rd1   (rf_rd1),
		.rd2   (rf_rd2),
		.rd3   (rf_rd3)
	);

endmodule

`default_nettype wire

//--- tb/rv_exe_assert.sv
// ----------------------------------------
// rv_exe_assert
// bus and write-back rules on rv_exe_top,
// attached through bind
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_exe_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       cyc,
	input logic       stb,
	input logic       ack,
	input logic       wb_val,
	input logic       wb_we,
	input logic [4:0] wb_rd
);

	// failures seen so far
	int unsigned assert_fails = 0;

	// ack lasts exactly one cycle
	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else begin
			$error("ack high for two cycles in a row");
			assert_fails++;
		end

	// no ack without a strobe the cycle before
	ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> $past(cyc && stb))
		else begin
			$error("ack without a preceding strobe");
			assert_fails++;
		end

	// write-back never targets x0
	no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_val && wb_we) |-> (wb_rd != 5'd0))
		else begin
			$error("write-back register writes x0");
			assert_fails++;
		end

endmodule

bind rv_exe_top rv_exe_assert u_assert (
	.clk    (clk),
	.rst_n  (rst_n),
	.cyc    (cyc),
	.stb    (stb),
	.ack    (ack),
	.wb_val (wb_val),
	.wb_we  (wb_we),
	.wb_rd  (wb_rd)
);

`default_nettype wire

//--- tb/rv_exe_tb.sv
// ----------------------------------------
// rv_exe_tb
// testbench for the rv32i execution pipeline
// drives instructions and readback over the
// wishbone port and checks against a model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_exe_tb;

	// roughly 400 bus transactions with up to ten cycles each
	localparam int n_trans        = 400;
	localparam int timeout_cycles = n_trans * 10;

	// OP ops from the low bits up
	// add sub sll slt sltu xor srl sra or and
	localparam logic [29:0] op_f3_tab   = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4,
	                                       3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
	localparam logic [9:0]  op_alt_tab  = 10'b0010000010;
	// OP-IMM ops from the low bits up
	// addi slli slti sltiu xori srli srai ori andi
	localparam logic [26:0] imm_f3_tab  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4,
	                                       3'd3, 3'd2, 3'd1, 3'd0};
	localparam logic [8:0]  imm_alt_tab = 9'b001000000;
	// branch funct3 for beq bne blt bge bltu bgeu
	localparam logic [17:0] cnd_tab     = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

	logic                              clk = 1'b0;
	logic                              rst_n;
	logic                              cyc;
	logic                              stb;
	logic                              we;
	logic [rv_exe_pkg::wb_adr_w-1:0]   adr;
	logic [rv_exe_pkg::xlen-1:0]       dat_w;
	logic [rv_exe_pkg::xlen-1:0]       dat_r;
	logic                              ack;

	// model state
	logic [31:0] model_regs [0:31];
	int unsigned model_taken;

	// pending compares
	string       name_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];

	int errors;
	int checks;
	int cycles;

	rv_exe_top dut (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic [4:0]         sh;
		logic [31:0]        res;
		sa = a;
		sb = b;
		sh = b[4:0];
		case (f3)
			3'd0: res = alt ? a - b : a + b;
			3'd1: res = a << sh;
			3'd2: res = (sa < sb) ? 32'd1 : 32'd0;
			3'd3: res = (a < b) ? 32'd1 : 32'd0;
			3'd4: res = a ^ b;
			3'd5: begin
				// arithmetic shift on the signed copy
				if (alt) begin
					res = sa >>> sh;
				end else begin
					res = a >> sh;
				end
			end
			3'd6: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic               t;
		sa = a;
		sb = b;
		case (f3)
			3'd0: t = (a == b);
			3'd1: t = (a != b);
			3'd4: t = (sa < sb);
			3'd5: t = (sa >= sb);
			3'd6: t = (a < b);
			3'd7: t = (a >= b);
			default: t = 1'b0;
		endcase
		return t;
	endfunction

	// one instruction applied to the model registers and taken count
	function automatic void ref_exec(input logic [31:0] w);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] res;
		logic        wr;
		rd    = w[11:7];
		f3    = w[14:12];
		a     = model_regs[w[19:15]];
		b     = model_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		res   = 32'd0;
		wr    = 1'b0;
		case (w[6:0])
			rv_exe_pkg::opc_op: begin
				wr  = 1'b1;
				res = compute_alu(f3, w[30], a, b);
			end
			rv_exe_pkg::opc_op_imm: begin
				// only the right shift has an alternate form
				wr  = 1'b1;
				res = compute_alu(f3, (f3 == 3'd5) && w[30], a, imm_i);
			end
			rv_exe_pkg::opc_lui: begin
				wr  = 1'b1;
				res = {w[31:12], 12'b0};
			end
			rv_exe_pkg::opc_branch: begin
				if (branch_taken(f3, a, b)) begin
					model_taken++;
				end
			end
			default: begin
				wr = 1'b0;
			end
		endcase
		if (wr && (rd != 5'd0)) begin
			model_regs[rd] = res;
		end
	endfunction

	// instruction word builders
	function automatic logic [31:0] r_type_word(input logic alt, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_exe_pkg::opc_op};
	endfunction

	function automatic logic [31:0] i_type_word(input logic [11:0] imm12,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm12, rs1, f3, rd, rv_exe_pkg::opc_op_imm};
	endfunction

	function automatic logic [31:0] lui_word(input logic [19:0] imm20, input logic [4:0] rd);
		return {imm20, rd, rv_exe_pkg::opc_lui};
	endfunction

	function automatic logic [31:0] branch_word(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [2:0] f3);
		return {7'b0, rs2, rs1, f3, 5'b0, rv_exe_pkg::opc_branch};
	endfunction

	// ----------------------------------------
	// bus tasks start and end on a falling edge
	// ----------------------------------------
	task automatic bus_write(input logic [5:0] a, input logic [31:0] d);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = a;
		dat_w = d;
		@(negedge clk);
		while (!ack) begin
			@(negedge clk);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		// stb low for one full cycle
		@(negedge clk);
	endtask

	task automatic bus_read(input logic [5:0] a, output logic [31:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = a;
		@(negedge clk);
		while (!ack) begin
			@(negedge clk);
		end
		// dat_r valid with ack
		d   = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_check(input string name, input logic [5:0] a, input logic [31:0] e);
		logic [31:0] d;
		bus_read(a, d);
		name_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(d);
	endtask

	task automatic exec_instr(input logic [31:0] w);
		bus_write(rv_exe_pkg::adr_instr, w);
		ref_exec(w);
	endtask

	// lui then addi with the upper part rounded for the sign of the low 12 bits
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		exec_instr(lui_word(v[31:12] + {19'b0, v[11]}, rd));
		exec_instr(i_type_word(v[11:0], rd, 3'd0, rd));
	endtask

	task automatic check_all_regs(input string tag);
		for (int i = 0; i < 32; i++) begin
			read_check($sformatf("%s x%0d", tag, i), i[5:0], model_regs[i]);
		end
		read_check({tag, " brcnt"}, rv_exe_pkg::adr_brcnt, model_taken);
	endtask

	task automatic check_val(input string name, input logic [31:0] e, input logic [31:0] a);
		checks++;
		if (e !== a) begin
			errors++;
			$display("** Error: %s expected %08h actual %08h", name, e, a);
		end
	endtask

	// compare process
	always @(posedge clk) begin
		while (exp_q.size() != 0) begin
			check_val(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, a bus cycle never completed", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] rnd;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm12;
		logic [6:0]  bad_opc [0:5];
		cyc    = 1'b0;
		stb    = 1'b0;
		we     = 1'b0;
		adr    = '0;
		dat_w  = '0;
		rst_n  = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		void'($urandom(32'haa67614b));
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = 32'd0;
		end
		model_taken = 0;
		// load store jal jalr auipc system
		bad_opc = '{7'b0000011, 7'b0100011, 7'b1101111, 7'b1100111, 7'b0010111, 7'b1110011};
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// everything reads zero out of reset
		check_all_regs("reset");

		// dependent chain
		exec_instr(i_type_word(12'h123, 5'd0, 3'd0, 5'd1));
		exec_instr(r_type_word(1'b0, 5'd1, 5'd1, 3'd0, 5'd2));
		exec_instr(r_type_word(1'b1, 5'd1, 5'd2, 3'd0, 5'd3));
		for (int i = 1; i < 4; i++) begin
			read_check($sformatf("chain x%0d", i), i[5:0], model_regs[i]);
		end

		// all OP and OP-IMM ops with rs1 forced negative in the second round
		for (int round = 0; round < 2; round++) begin
			for (int k = 0; k < 10; k++) begin
				va = $urandom();
				vb = $urandom();
				if (round == 1) begin
					va[31] = 1'b1;
				end
				load_const(5'd5, va);
				load_const(5'd6, vb);
				rd = 5'd10 + k[4:0];
				exec_instr(r_type_word(op_alt_tab[k], 5'd6, 5'd5, op_f3_tab[k*3 +: 3], rd));
				read_check($sformatf("op %0d round %0d", k, round), {1'b0, rd}, model_regs[rd]);
			end
			for (int k = 0; k < 9; k++) begin
				va = $urandom();
				rnd = $urandom();
				if (round == 1) begin
					va[31] = 1'b1;
				end
				load_const(5'd5, va);
				f3  = imm_f3_tab[k*3 +: 3];
				alt = imm_alt_tab[k];
				imm12 = rnd[11:0];
				// shifts carry funct7 in the upper immediate bits
				if ((f3 == 3'd1) || (f3 == 3'd5)) begin
					imm12 = {1'b0, alt, 5'b0, rnd[4:0]};
				end
				rd = 5'd20 + k[4:0];
				exec_instr(i_type_word(imm12, 5'd5, f3, rd));
				read_check($sformatf("opimm %0d round %0d", k, round), {1'b0, rd}, model_regs[rd]);
			end
		end

		// x0 stays zero
		exec_instr(i_type_word(12'h07b, 5'd0, 3'd0, 5'd0));
		exec_instr(r_type_word(1'b0, 5'd6, 5'd5, 3'd0, 5'd0));
		exec_instr(lui_word(20'hfffff, 5'd0));
		read_check("x0 after writes", 6'd0, 32'd0);

		// branches with x8 negative and x9 positive so signed and unsigned differ
		va = $urandom();
		vb = $urandom();
		va[31] = 1'b1;
		vb[31] = 1'b0;
		load_const(5'd8, va);
		load_const(5'd9, vb);
		for (int k = 0; k < 6; k++) begin
			f3 = cnd_tab[k*3 +: 3];
			exec_instr(branch_word(5'd9, 5'd8, f3));
			exec_instr(branch_word(5'd8, 5'd8, f3));
			exec_instr(branch_word(5'd8, 5'd9, f3));
		end
		check_all_regs("branch");

		// unsupported opcodes and writes to other addresses
		for (int k = 0; k < 6; k++) begin
			rnd = $urandom();
			exec_instr({rnd[31:7], bad_opc[k]});
		end
		bus_write(6'd5, $urandom());
		bus_write(6'd17, $urandom());
		bus_write(rv_exe_pkg::adr_brcnt, $urandom());
		bus_write(6'd45, $urandom());
		check_all_regs("ignored");

		// let the compare process drain
		repeat (2) @(posedge clk);
		errors += dut.u_assert.assert_fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hdl/rv_exe_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decode_stage.sv
hdl/rv_exe_stage.sv
hdl/rv_exe_top.sv
tb/rv_exe_assert.sv
tb/rv_exe_tb.sv

//--- Bender.yml
package:
  name: rv_exe

sources:
  - files:
      - hdl/rv_exe_pkg.sv
      - hdl/rv_alu.sv
      - hdl/rv_regfile.sv
      - hdl/rv_decode_stage.sv
      - hdl/rv_exe_stage.sv
      - hdl/rv_exe_top.sv
  - target: simulation
    files:
      - tb/rv_exe_assert.sv
      - tb/rv_exe_tb.sv
